/* verilog/blit_pkg.sv */
// shared blitter types and register map; VRAM words and addresses are fixed at 16 bits

package blit_pkg;

    typedef logic [15:0] word_t;            // VRAM data word
    typedef logic [15:0] addr_t;            // VRAM word address
    typedef logic [3:0]  reg_num_t;         // host register number
    typedef logic [3:0]  nib_mask_t;        // one enable per nibble of a word

    // combine operation, C is always xored last
    typedef enum logic [1:0] {
        OP_A_XOR_C       = 2'd0,            // D = A ^ C
        OP_A_AND_B_XOR_C = 2'd1,            // D = (A & B) ^ C
        OP_A_XOR_B_XOR_C = 2'd2,            // D = A ^ B ^ C
        OP_A_ADD_B_XOR_C = 2'd3             // nibble-wise add, carries dropped
    } blit_op_t;

    // which operand decides transparency, and at what grain
    typedef enum logic [1:0] {
        TRANS_A_4B = 2'd0,                  // zero nibbles of A are kept
        TRANS_A_8B = 2'd1,                  // zero bytes of A are kept
        TRANS_B_4B = 2'd2,
        TRANS_B_8B = 2'd3
    } blit_trans_t;

    // host register numbers, the rest read zero
    localparam reg_num_t REG_CTRL  = 4'd0;
    localparam reg_num_t REG_MOD_A = 4'd1;
    localparam reg_num_t REG_MOD_B = 4'd2;
    localparam reg_num_t REG_MOD_D = 4'd3;
    localparam reg_num_t REG_SRC_A = 4'd4;
    localparam reg_num_t REG_SRC_B = 4'd5;
    localparam reg_num_t REG_VAL_C = 4'd6;
    localparam reg_num_t REG_DST_D = 4'd7;
    localparam reg_num_t REG_LINES = 4'd8;
    localparam reg_num_t REG_COUNT = 4'd9;  // writing here queues the blit

    // CTRL bit positions
    localparam int CTRL_A_CONST = 0;
    localparam int CTRL_B_CONST = 1;
    localparam int CTRL_TRANS   = 2;        // two bits
    localparam int CTRL_OP      = 4;        // two bits

    // one full blit description as held in the queue slot
    typedef struct packed {
        logic        a_const;               // A taken from src_a, never read
        logic        b_const;               // B taken from src_b, never read
        blit_trans_t trans;
        blit_op_t    op;
        word_t       mod_a;                 // added to A address at line end
        word_t       mod_b;
        word_t       mod_d;
        word_t       src_a;
        word_t       src_b;
        word_t       val_c;
        word_t       dst_d;
        word_t       lines;                 // line count minus one
        word_t       count;                 // words per line minus one
    } blit_cfg_t;

endpackage

/* verilog/blit_alu.sv */
// combinational D = f(A, B) ^ C with a nibble write mask; no shifting or edge masks

`timescale 1ns/1ps

module blit_alu (
    input  blit_pkg::blit_op_t     op_i,
    input  blit_pkg::blit_trans_t  trans_i,
    input  blit_pkg::word_t        val_a_i,
    input  blit_pkg::word_t        val_b_i,
    input  blit_pkg::word_t        val_c_i,
    output blit_pkg::word_t        val_d_o,
    output blit_pkg::nib_mask_t    mask_o       // bit n enables nibble n
);

    blit_pkg::word_t  nib_sum;                  // A + B per nibble
    blit_pkg::word_t  sel_word;                 // operand that decides transparency

    // four independent 4-bit adds, carries lost
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            nib_sum[4*i +: 4] = val_a_i[4*i +: 4] + val_b_i[4*i +: 4];
        end
    end

    always_comb begin
        case (op_i)
            blit_pkg::OP_A_XOR_C:       val_d_o = val_a_i ^ val_c_i;
            blit_pkg::OP_A_AND_B_XOR_C: val_d_o = (val_a_i & val_b_i) ^ val_c_i;
            blit_pkg::OP_A_XOR_B_XOR_C: val_d_o = val_a_i ^ val_b_i ^ val_c_i;
            default:                    val_d_o = nib_sum ^ val_c_i;
        endcase
    end

    // zero nibbles or bytes of the selector leave memory untouched
    always_comb begin
        case (trans_i)
            blit_pkg::TRANS_A_4B,
            blit_pkg::TRANS_A_8B: sel_word = val_a_i;
            default:              sel_word = val_b_i;
        endcase

        if (trans_i == blit_pkg::TRANS_A_8B || trans_i == blit_pkg::TRANS_B_8B) begin
            mask_o = {{2{|sel_word[15:8]}}, {2{|sel_word[7:0]}}};   // byte grain
        end else begin
            mask_o = {|sel_word[15:12], |sel_word[11:8],
                      |sel_word[7:4],   |sel_word[3:0]};
        end
    end

endmodule

/* verilog/blit_engine.sv */
// blit sequencer; reads B then A per word, writes D; addresses wrap at 64K words

`timescale 1ns/1ps

module blit_engine (
    input  logic                 clk,
    input  logic                 reset_i,
    input  blit_pkg::blit_cfg_t  cfg_i,
    input  logic                 queued_i,
    output logic                 take_o,            // pulse in SETUP
    output logic                 busy_o,
    output logic                 done_o,            // one cycle per finished blit
    output logic                 vram_sel_o,
    output logic                 vram_wr_o,
    output blit_pkg::nib_mask_t  vram_wr_mask_o,
    output blit_pkg::addr_t      vram_addr_o,
    output blit_pkg::word_t      vram_data_o,
    input  blit_pkg::word_t      vram_data_i,
    input  logic                 vram_ack_i
);

    typedef enum logic [3:0] {
        IDLE, SETUP, RD, WAIT_RD_B, WAIT_RD_A, EXEC, WAIT_WR_D, LINE_DONE, DONE
    } state_t;

    state_t                  state;

    // working copy of the running blit
    logic                    a_const;
    logic                    b_const;
    blit_pkg::blit_trans_t   trans;
    blit_pkg::blit_op_t      op;
    blit_pkg::word_t         mod_a;
    blit_pkg::word_t         mod_b;
    blit_pkg::word_t         mod_d;
    blit_pkg::word_t         val_c;
    blit_pkg::word_t         width;
    blit_pkg::addr_t         addr_a;
    blit_pkg::addr_t         addr_b;
    blit_pkg::addr_t         addr_d;
    blit_pkg::word_t         val_a;
    blit_pkg::word_t         val_b;
    logic [16:0]             word_cnt;              // top bit set on the last word
    logic [16:0]             line_cnt;              // top bit set on the last line

    blit_pkg::word_t         alu_d;
    blit_pkg::nib_mask_t     alu_mask;

    assign take_o = (state == SETUP);
    assign busy_o = (state != IDLE);

    blit_alu u_alu (
        .op_i     (op),
        .trans_i  (trans),
        .val_a_i  (val_a),
        .val_b_i  (val_b),
        .val_c_i  (val_c),
        .val_d_o  (alu_d),
        .mask_o   (alu_mask)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= IDLE;
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;

            case (state)
                IDLE: begin
                    if (queued_i) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    a_const  <= cfg_i.a_const;
                    b_const  <= cfg_i.b_const;
                    trans    <= cfg_i.trans;
                    op       <= cfg_i.op;
                    mod_a    <= cfg_i.mod_a;
                    mod_b    <= cfg_i.mod_b;
                    mod_d    <= cfg_i.mod_d;
                    val_c    <= cfg_i.val_c;
                    width    <= cfg_i.count;
                    addr_a   <= cfg_i.src_a;
                    addr_b   <= cfg_i.src_b;
                    addr_d   <= cfg_i.dst_d;
                    val_a    <= cfg_i.src_a;            // used as is when A is constant
                    val_b    <= cfg_i.src_b;
                    line_cnt <= {1'b0, cfg_i.lines};
                    state    <= RD;
                end
                RD, WAIT_WR_D: begin
                    if (state == RD) begin
                        line_cnt <= line_cnt - 17'd1;
                        word_cnt <= {1'b0, width} - 17'd1;
                    end else if (vram_ack_i) begin
                        word_cnt <= word_cnt - 17'd1;
                    end

                    if (state == WAIT_WR_D && !vram_ack_i) begin
                        state <= WAIT_WR_D;             // hold the write request
                    end else if (state == WAIT_WR_D && word_cnt[16]) begin
                        vram_sel_o <= 1'b0;
                        vram_wr_o  <= 1'b0;
                        state      <= LINE_DONE;
                    end else if (!b_const) begin
                        vram_sel_o <= 1'b1;
                        vram_wr_o  <= 1'b0;
                        vram_addr_o <= addr_b;
                        addr_b     <= addr_b + 16'd1;
                        state      <= WAIT_RD_B;
                    end else if (!a_const) begin
                        vram_sel_o <= 1'b1;
                        vram_wr_o  <= 1'b0;
                        vram_addr_o <= addr_a;
                        addr_a     <= addr_a + 16'd1;
                        state      <= WAIT_RD_A;
                    end else begin
                        vram_sel_o <= 1'b0;
                        vram_wr_o  <= 1'b0;
                        state      <= EXEC;             // both constant, straight to write
                    end
                end
                WAIT_RD_B: begin
                    if (vram_ack_i) begin
                        val_b <= vram_data_i;
                        if (!a_const) begin
                            vram_addr_o <= addr_a;      // sel stays up for the A read
                            addr_a      <= addr_a + 16'd1;
                            state       <= WAIT_RD_A;
                        end else begin
                            vram_sel_o <= 1'b0;
                            state      <= EXEC;
                        end
                    end
                end
                WAIT_RD_A: begin
                    if (vram_ack_i) begin
                        val_a      <= vram_data_i;
                        vram_sel_o <= 1'b0;
                        state      <= EXEC;
                    end
                end
                EXEC: begin
                    vram_sel_o     <= 1'b1;
                    vram_wr_o      <= 1'b1;
                    vram_addr_o    <= addr_d;
                    vram_data_o    <= alu_d;
                    vram_wr_mask_o <= alu_mask;         // registered with the request
                    addr_d         <= addr_d + 16'd1;
                    state          <= WAIT_WR_D;
                end
                LINE_DONE: begin
                    addr_a <= addr_a + mod_a;
                    addr_b <= addr_b + mod_b;
                    addr_d <= addr_d + mod_d;
                    state  <= line_cnt[16] ? DONE : RD;
                end
                DONE: begin
                    done_o <= 1'b1;
                    state  <= queued_i ? SETUP : IDLE;  // next blit skips IDLE
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/blit_regs.sv */
// host register bank with a one-deep blit queue; writes while full overwrite the queued blit

`timescale 1ns/1ps

module blit_regs (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 reg_wr_i,      // one cycle write strobe
    input  blit_pkg::reg_num_t   reg_num_i,
    input  blit_pkg::word_t      reg_data_i,
    output blit_pkg::word_t      reg_data_o,    // registered read-back
    input  logic                 take_i,        // engine copies cfg_o this cycle
    output blit_pkg::blit_cfg_t  cfg_o,
    output logic                 queued_o       // slot holds a blit not yet taken
);

    // host writes and queue flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o    <= '0;
            queued_o <= 1'b0;
        end else begin
            if (take_i) begin
                queued_o <= 1'b0;
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    blit_pkg::REG_CTRL: begin
                        cfg_o.a_const <= reg_data_i[blit_pkg::CTRL_A_CONST];
                        cfg_o.b_const <= reg_data_i[blit_pkg::CTRL_B_CONST];
                        cfg_o.trans   <= blit_pkg::blit_trans_t'(
                                             reg_data_i[blit_pkg::CTRL_TRANS +: 2]);
                        cfg_o.op      <= blit_pkg::blit_op_t'(
                                             reg_data_i[blit_pkg::CTRL_OP +: 2]);
                    end
                    blit_pkg::REG_MOD_A: begin
                        cfg_o.mod_a <= reg_data_i;
                    end
                    blit_pkg::REG_MOD_B: begin
                        cfg_o.mod_b <= reg_data_i;
                    end
                    blit_pkg::REG_MOD_D: begin
                        cfg_o.mod_d <= reg_data_i;
                    end
                    blit_pkg::REG_SRC_A: begin
                        cfg_o.src_a <= reg_data_i;
                    end
                    blit_pkg::REG_SRC_B: begin
                        cfg_o.src_b <= reg_data_i;
                    end
                    blit_pkg::REG_VAL_C: begin
                        cfg_o.val_c <= reg_data_i;
                    end
                    blit_pkg::REG_DST_D: begin
                        cfg_o.dst_d <= reg_data_i;
                    end
                    blit_pkg::REG_LINES: begin
                        cfg_o.lines <= reg_data_i;
                    end
                    blit_pkg::REG_COUNT: begin
                        cfg_o.count <= reg_data_i;
                        queued_o    <= 1'b1;        // overrides a take in the same cycle
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read-back mux, one cycle behind reg_num_i
    always_ff @(posedge clk) begin
        case (reg_num_i)
            blit_pkg::REG_CTRL:  reg_data_o <= {10'd0, cfg_o.op, cfg_o.trans,
                                                cfg_o.b_const, cfg_o.a_const};
            blit_pkg::REG_MOD_A: reg_data_o <= cfg_o.mod_a;
            blit_pkg::REG_MOD_B: reg_data_o <= cfg_o.mod_b;
            blit_pkg::REG_MOD_D: reg_data_o <= cfg_o.mod_d;
            blit_pkg::REG_SRC_A: reg_data_o <= cfg_o.src_a;
            blit_pkg::REG_SRC_B: reg_data_o <= cfg_o.src_b;
            blit_pkg::REG_VAL_C: reg_data_o <= cfg_o.val_c;
            blit_pkg::REG_DST_D: reg_data_o <= cfg_o.dst_d;
            blit_pkg::REG_LINES: reg_data_o <= cfg_o.lines;
            blit_pkg::REG_COUNT: reg_data_o <= cfg_o.count;
            default:             reg_data_o <= '0;      // unmapped numbers
        endcase
    end

endmodule

/* verilog/blitter.sv */
// blitter top; one queued blit behind the running one, VRAM bus uses sel/ack level handshake

`timescale 1ns/1ps

module blitter (
    input  logic                 clk,
    input  logic                 reset_i,
    // host register port
    input  logic                 reg_wr_i,
    input  blit_pkg::reg_num_t   reg_num_i,
    input  blit_pkg::word_t      reg_data_i,
    output blit_pkg::word_t      reg_data_o,
    // status
    output logic                 busy_o,
    output logic                 full_o,
    output logic                 done_o,
    // VRAM bus
    output logic                 vram_sel_o,
    output logic                 vram_wr_o,
    output blit_pkg::nib_mask_t  vram_wr_mask_o,
    output blit_pkg::addr_t      vram_addr_o,
    output blit_pkg::word_t      vram_data_o,
    input  blit_pkg::word_t      vram_data_i,
    input  logic                 vram_ack_i
);

    blit_pkg::blit_cfg_t  cfg;                  // queued blit description
    logic                 queued;
    logic                 take;

    assign full_o = queued;

    blit_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .reg_data_o (reg_data_o),
        .take_i     (take),
        .cfg_o      (cfg),
        .queued_o   (queued)
    );

    blit_engine u_engine (
        .clk            (clk),
        .reset_i        (reset_i),
        .cfg_i          (cfg),
        .queued_i       (queued),
        .take_o         (take),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .vram_sel_o     (vram_sel_o),
        .vram_wr_o      (vram_wr_o),
        .vram_wr_mask_o (vram_wr_mask_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_o    (vram_data_o),
        .vram_data_i    (vram_data_i),
        .vram_ack_i     (vram_ack_i)
    );

endmodule

/* test/tb_clock.sv */
// testbench clock, 100 ns period; reset held high for the first 8 rising edges

`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        repeat (8) @(posedge clk_o);
        #1 reset_o = 1'b0;                  // released just after the 8th edge
    end

endmodule

/* test/tb_blitter.sv */
// blitter testbench; run from the project root, VRAM model acks after 0 to 3 random cycles

`timescale 1ns/1ps

module tb_blitter;

    logic        clk, reset;
    logic        reg_wr_i, busy_o, full_o, done_o;
    logic [3:0]  reg_num_i, vram_wr_mask_o;
    logic [15:0] reg_data_i, reg_data_o, vram_addr_o, vram_data_o, vram_data_i;
    logic        vram_sel_o, vram_wr_o, vram_ack_i;

    logic [15:0] mem [0:65535];             // VRAM as the DUT sees it
    logic [15:0] exp_mem [0:65535];         // reference copy
    logic [16:0] exp_acc [$];               // expected accesses as {wr, addr}
    logic [15:0] tv [0:63][0:11];           // row 0 is the register test
    integer      seed;
    int          err_cnt, pass_cnt, fail_cnt, done_cnt, delay, tnum;
    logic        pending, abort;

    tb_clock u_clock (.clk_o(clk), .reset_o(reset));

    blitter u_blitter (
        .clk(clk), .reset_i(reset), .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o), .busy_o(busy_o),
        .full_o(full_o), .done_o(done_o), .vram_sel_o(vram_sel_o), .vram_wr_o(vram_wr_o),
        .vram_wr_mask_o(vram_wr_mask_o), .vram_addr_o(vram_addr_o),
        .vram_data_o(vram_data_o), .vram_data_i(vram_data_i), .vram_ack_i(vram_ack_i)
    );

    function automatic logic [15:0] combine(logic [1:0] op, logic [15:0] a, b, c);
        logic [15:0] s;
        for (int n = 0; n < 4; n++) begin
            s[4*n +: 4] = a[4*n +: 4] + b[4*n +: 4];   // no carry between nibbles
        end
        case (op)
            2'd0:    return a ^ c;
            2'd1:    return (a & b) ^ c;
            2'd2:    return a ^ b ^ c;
            default: return s ^ c;
        endcase
    endfunction

    function automatic logic [3:0] nib_mask(logic [1:0] trans, logic [15:0] a, b);
        logic [15:0] s;
        s = trans[1] ? b : a;
        if (trans[0]) begin
            return {{2{|s[15:8]}}, {2{|s[7:0]}}};
        end
        return {|s[15:12], |s[11:8], |s[7:4], |s[3:0]};
    endfunction

    function automatic logic [15:0] merge(logic [15:0] old, logic [15:0] val, logic [3:0] m);
        logic [15:0] w;
        w = old;
        for (int n = 0; n < 4; n++) begin
            if (m[n]) w[4*n +: 4] = val[4*n +: 4];
        end
        return w;
    endfunction

    // some nibbles and bytes forced to zero so transparency gets exercised
    function automatic logic [15:0] fill_word(logic [15:0] a, logic [15:0] s);
        logic [31:0] h;
        logic [15:0] w;
        h = {16'd0, a} * 32'h0000_9e37;
        w = h[15:0] ^ h[31:16] ^ s ^ {a[7:0], a[15:8]};
        if (a[2]) w[7:0] = 8'd0;
        if (a[4]) w[15:12] = 4'd0;
        return w;
    endfunction

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (got !== exp) begin
            $display("Error %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [15:0] data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        tick();
        reg_wr_i   = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] num, output logic [15:0] val);
        reg_num_i = num;
        tick();
        val = reg_data_o;
    endtask

    task automatic preload(input logic [15:0] s);
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a = i[15:0];
            mem[a]     = fill_word(a, s);
            exp_mem[a] = mem[a];
        end
    endtask

    // walks the rectangle in bus order with B, A and then D per word
    task automatic ref_blit(input int idx);
        logic [15:0] ctrl, aa, bb, dd, a, b;
        ctrl = tv[idx][0];
        aa   = tv[idx][4];
        bb   = tv[idx][5];
        dd   = tv[idx][7];
        for (int l = 0; l <= int'(tv[idx][8]); l++) begin
            for (int w = 0; w <= int'(tv[idx][9]); w++) begin
                a = tv[idx][4];
                b = tv[idx][5];
                if (!ctrl[1]) begin
                    b = exp_mem[bb];
                    exp_acc.push_back({1'b0, bb});
                    bb = bb + 16'd1;
                end
                if (!ctrl[0]) begin
                    a = exp_mem[aa];
                    exp_acc.push_back({1'b0, aa});
                    aa = aa + 16'd1;
                end
                exp_mem[dd] = merge(exp_mem[dd], combine(ctrl[5:4], a, b, tv[idx][6]),
                                    nib_mask(ctrl[3:2], a, b));
                exp_acc.push_back({1'b1, dd});
                dd = dd + 16'd1;
            end
            aa = aa + tv[idx][1];
            bb = bb + tv[idx][2];
            dd = dd + tv[idx][3];
        end
    endtask

    task automatic queue_blit(input int idx);
        for (int r = 0; r < 9; r++) begin
            write_reg(4'(r), tv[idx][r]);
        end
        ref_blit(idx);
        write_reg(4'd9, tv[idx][9]);
        check("full_o", 16'd1, {15'd0, full_o});
    endtask

    task automatic finish_blit(input int target);
        int n;
        n = 0;
        while (!(done_cnt >= target && !busy_o) && n < 100000) begin
            tick();
            n++;
        end
        if (n >= 100000) begin
            $display("timeout waiting for the blit to finish");
            abort = 1'b1;
        end
        check("done_o pulses", 16'(target), 16'(done_cnt));
        for (int i = 0; i < 65536; i++) begin
            if (mem[i[15:0]] !== exp_mem[i[15:0]])
                check($sformatf("vram[%h]", i[15:0]), exp_mem[i[15:0]], mem[i[15:0]]);
        end
        if (exp_acc.size() != 0) begin
            $display("%0d expected VRAM accesses never happened", exp_acc.size());
            err_cnt++;
            exp_acc.delete();
        end
    endtask

    task automatic run_row(input int idx);
        int n;
        preload(tv[idx][10]);
        done_cnt = 0;
        queue_blit(idx);
        if (tv[idx][11][0]) begin
            n = 0;
            while (full_o && n < 1000) begin         // engine takes the first blit
                tick();
                n++;
            end
            if (full_o) begin
                $display("timeout waiting for the engine to take the first blit");
                abort = 1'b1;
            end
            queue_blit(idx + 1);
            check("busy_o", 16'd1, {15'd0, busy_o});
        end
        finish_blit(tv[idx][11][0] ? 2 : 1);
    endtask

    task automatic end_test(input int err0);
        if (err_cnt == err0) begin
            pass_cnt++;
            $display("test %0d passed", tnum);
        end else begin
            fail_cnt++;
            $display("test %0d failed with %0d errors", tnum, err_cnt - err0);
        end
        tnum++;
    endtask

    always @(negedge clk) begin
        if (!reset && done_o) done_cnt++;
    end

    // VRAM model that acks each request after 0 to 3 cycles
    always begin : vram_model
        int          rnd;
        logic [16:0] e;
        @(posedge clk);
        #1;
        if (reset || vram_ack_i) begin
            vram_ack_i = 1'b0;
            pending    = 1'b0;
        end else if (vram_sel_o) begin
            if (!pending) begin
                rnd     = $random(seed);
                delay   = rnd & 3;
                pending = 1'b1;
            end
            if (delay > 0) begin
                delay--;
            end else begin
                if (exp_acc.size() == 0) begin
                    $display("unexpected VRAM access at address %h", vram_addr_o);
                    err_cnt++;
                end else begin
                    e = exp_acc.pop_front();
                    check("vram_wr_o", {15'd0, e[16]}, {15'd0, vram_wr_o});
                    check("vram_addr_o", e[15:0], vram_addr_o);
                end
                if (vram_wr_o)
                    mem[vram_addr_o] = merge(mem[vram_addr_o], vram_data_o, vram_wr_mask_o);
                else
                    vram_data_i = mem[vram_addr_o];
                vram_ack_i = 1'b1;
            end
        end
    end

    initial begin
        int          fd, r, nrows, exp_pass, row_pass, step, err0, idx, n;
        string       line;
        logic [15:0] f [0:11];
        logic [15:0] v, e;
        seed = 14515;
        reg_wr_i = 1'b0;
        reg_num_i = 4'd0;
        reg_data_i = 16'd0;
        vram_data_i = 16'd0;
        vram_ack_i = 1'b0;
        pending = 1'b0;
        abort = 1'b0;
        {err_cnt, pass_cnt, fail_cnt, done_cnt, delay, nrows, exp_pass, row_pass, tnum} = '0;

        fd = $fopen("test/blitter_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file");
            abort = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r == 0 || line.len() < 2 || line[0] == "#") begin
                end else if (line[0] == "p") begin
                    r = $sscanf(line.substr(4, line.len() - 1), "%d", exp_pass);
                end else if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                             f[9], f[10], f[11]) == 12) begin
                    nrows++;
                    for (int k = 0; k < 12; k++) tv[nrows][k] = f[k];
                end else begin
                    $display("bad line in the test file");
                    err_cnt++;
                end
            end
            $fclose(fd);
        end

        n = 0;
        while (reset && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (reset) begin
            $display("timeout waiting for reset to be released");
            abort = 1'b1;
        end
        tick();

        // state after reset
        err0 = err_cnt;
        check("busy_o", 16'd0, {15'd0, busy_o});
        check("full_o", 16'd0, {15'd0, full_o});
        check("done_o", 16'd0, {15'd0, done_o});
        check("vram_sel_o", 16'd0, {15'd0, vram_sel_o});
        for (int k = 0; k < 16; k++) begin
            read_reg(4'(k), v);
            check($sformatf("reg_data_o[%0d]", k), 16'd0, v);
        end
        end_test(err0);

        // register read-back and then a small blit from the written values
        err0 = err_cnt;
        for (int k = 0; k < 9; k++) begin
            r = $random(seed);
            tv[0][k] = r[15:0];
        end
        tv[0][8] = {14'd0, tv[0][8][1:0]};
        tv[0][9] = {13'd0, tv[0][7][2:0]};
        preload(16'h5eed);
        done_cnt = 0;
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            if (k != 9) write_reg(4'(k), k < 9 ? tv[0][k] : r[15:0]);
        end
        for (int k = 0; k < 16; k++) begin
            read_reg(4'(k), v);
            e = (k < 9) ? tv[0][k] : 16'd0;
            if (k == 0) e = e & 16'h003f;
            check($sformatf("reg_data_o[%0d]", k), e, v);
        end
        ref_blit(0);
        write_reg(4'd9, tv[0][9]);
        check("full_o", 16'd1, {15'd0, full_o});
        finish_blit(1);
        read_reg(4'd9, v);
        check("reg_data_o[9]", tv[0][9], v);
        end_test(err0);

        // a pair of queued blits uses two rows of the test file
        idx = 1;
        while (idx <= nrows && !abort) begin
            err0 = err_cnt;
            step = tv[idx][11][0] ? 2 : 1;
            run_row(idx);
            end_test(err0);
            if (err_cnt == err0) row_pass += step;
            idx += step;
        end

        if (!abort && row_pass != exp_pass)
            $display("%0d test rows passed but the test file expects %0d", row_pass, exp_pass);
        $display("tests passed %0d failed %0d errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && !abort && row_pass == exp_pass) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* test/blitter_tests.txt */
# ctrl mod_a mod_b mod_d src_a src_b val_c dst_d lines count seed pair (hex)
# ctrl = op<<4 | trans<<2 | b_const<<1 | a_const; pair 1 queues the next row while this one runs
0000 0000 0000 0000 1000 2000 5a5a 3000 0000 0007 0011 0
0010 0000 0000 0000 1000 2000 00ff 3000 0000 0007 0022 0
0020 0000 0000 0000 1000 2000 f00f 3000 0000 0007 0033 0
0030 0000 0000 0000 1000 2000 1234 3000 0000 0007 0044 0
0020 0000 0000 0000 1100 2100 0000 3100 0000 000f 0101 0
0024 0000 0000 0000 1100 2100 0000 3100 0000 000f 0202 0
0028 0000 0000 0000 1100 2100 0000 3100 0000 000f 0303 0
002c 0000 0000 0000 1100 2100 0000 3100 0000 000f 0404 0
0030 000c 0020 0038 4000 5000 a5a5 6000 0005 0007 0505 0
0013 0011 0022 001a f0f0 3c3c 0101 7000 0003 0005 0606 0
0025 0010 0004 0008 00ff 5200 0f0f 7200 0002 0003 0707 0
003e 0004 0010 0008 4300 1200 8888 7300 0002 0004 0808 0
0024 0002 0003 fff0 4400 5400 0000 8000 0002 0003 0909 0
0020 0000 0000 0000 fff0 5500 3333 fffe 0000 0003 0a0a 0
0020 0004 0004 0008 9000 a000 0f0f b000 0003 0007 0b0b 1
0034 0002 0002 0004 9100 a100 f0f0 b100 0001 0003 0000 0
pass 16

/* sources.f */
verilog/blit_pkg.sv
verilog/blit_alu.sv
verilog/blit_engine.sv
verilog/blit_regs.sv
verilog/blitter.sv
test/tb_clock.sv
test/tb_blitter.sv

/* Makefile */
TOP = tb_blitter

compile:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean
